// ==== source/rename_pkg.sv ====
// rename package: sizes, tag and value types, reorder buffer entry states
package rename_pkg;

  // machine sizes
  localparam int num_arch  = 32;  // architectural registers, all renamed
  localparam int num_phys  = 64;  // physical registers
  localparam int num_fu    = 2;   // functional units, one read-port pair each
  localparam int rob_depth = 16;  // in-flight instructions

  // derived widths
  localparam int arch_width  = $clog2(num_arch);       // 5
  localparam int tag_width   = $clog2(num_phys);       // 6
  localparam int value_width = 64;                     // datapath width
  localparam int rob_width   = $clog2(rob_depth);      // 4, wraps naturally
  localparam int count_width = $clog2(rob_depth + 1);  // 5, holds 0..rob_depth

  // architectural register index
  typedef logic [arch_width-1:0] arch_reg_t;

  // physical register tag
  typedef logic [tag_width-1:0] phys_tag_t;

  // register value
  typedef logic [value_width-1:0] reg_value_t;

  // rob pointer
  typedef logic [rob_width-1:0] rob_index_t;

  // rob occupancy
  typedef logic [count_width-1:0] rob_count_t;

  // rob entry life cycle
  // empty on reset and after retire, issued at dispatch,
  // done once its tag shows up on the complete bus
  typedef enum logic [1:0] {
    empty  = 2'd0,  // slot unused
    issued = 2'd1,  // waiting for completion
    done   = 2'd2   // result written, may retire
  } rob_state_t;

endpackage

// ==== source/rename_if.sv ====
// rename interface: dispatch allocation shared by register file, map table and rob
interface rename_if;
  import rename_pkg::*;

  logic      fire;           // dispatch accepted this cycle
  arch_reg_t dest;           // destination being renamed
  phys_tag_t new_tag;        // lowest free tag
  logic      tag_available;  // free list not empty
  phys_tag_t old_tag;        // current mapping of dest

  // register file hands out tags
  modport prf (
    input  fire,
    output new_tag,
    output tag_available
  );

  // map table gives the old mapping and takes the new one
  modport map (
    input  fire,
    input  dest,
    input  new_tag,
    output old_tag
  );

  // rob decides acceptance and records both tags
  modport rob (
    output fire,
    output dest,
    input  new_tag,
    input  tag_available,
    input  old_tag
  );

endinterface

// ==== source/phys_reg_file.sv ====
// physical register file: values, free list, lowest-free allocation, forwarded reads
module phys_reg_file (
  input  logic                  clock,
  input  logic                  reset,
  rename_if.prf                 alloc,
  // complete bus
  input  logic                  complete_valid,
  input  rename_pkg::phys_tag_t  complete_tag,
  input  rename_pkg::reg_value_t complete_result,
  // retire frees the old tag
  input  logic                  retire_fire,
  input  rename_pkg::phys_tag_t  retire_old_tag,
  // functional unit operand reads
  input  rename_pkg::phys_tag_t  read_tag1   [rename_pkg::num_fu],
  input  rename_pkg::phys_tag_t  read_tag2   [rename_pkg::num_fu],
  output rename_pkg::reg_value_t read_value1 [rename_pkg::num_fu],
  output rename_pkg::reg_value_t read_value2 [rename_pkg::num_fu]
);
  import rename_pkg::*;

  reg_value_t          values [num_phys];  // register contents
  logic [num_phys-1:0] free_bits;          // 1 = tag can be allocated
  phys_tag_t           low_tag;            // scan result
  logic                any_free;           // scan found something

  // one read port, bus result wins over the stored value
  function automatic reg_value_t read_port(
    input phys_tag_t  tag,
    input logic       bus_valid,
    input phys_tag_t  bus_tag,
    input reg_value_t bus_result,
    input reg_value_t stored
  );
    reg_value_t result;
    if (bus_valid && bus_tag == tag) begin
      result = bus_result;  // same-cycle forward
    end else begin
      result = stored;
    end
    return result;
  endfunction

  // priority scan, walk down so the lowest free index is kept last
  always_comb begin
    low_tag  = '0;
    any_free = 1'b0;
    for (int i = num_phys - 1; i >= 0; i--) begin
      if (free_bits[i]) begin
        low_tag  = phys_tag_t'(i);
        any_free = 1'b1;
      end
    end
  end

  assign alloc.new_tag       = low_tag;   // offered to dispatch
  assign alloc.tag_available = any_free;  // feeds the rob accept decision

  // operand reads for every functional unit
  always_comb begin
    for (int f = 0; f < num_fu; f++) begin
      read_value1[f] = read_port(read_tag1[f], complete_valid, complete_tag,
                                 complete_result, values[read_tag1[f]]);
      read_value2[f] = read_port(read_tag2[f], complete_valid, complete_tag,
                                 complete_result, values[read_tag2[f]]);
    end
  end

  // free list update
  // allocated tag is free and retired tag is busy, so the two never collide
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < num_phys; i++) begin
        free_bits[i] <= (i >= num_arch);  // identity map owns 0..31
      end
    end else begin
      if (alloc.fire) begin
        free_bits[alloc.new_tag] <= 1'b0;  // taken by dispatch
      end
      if (retire_fire) begin
        free_bits[retire_old_tag] <= 1'b1;  // allocatable next cycle
      end
    end
  end

  // value array, cleared so the identity-mapped registers read zero
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < num_phys; i++) begin
        values[i] <= '0;
      end
    end else if (complete_valid) begin
      values[complete_tag] <= complete_result;  // writeback at the edge
    end
  end

endmodule

// ==== source/map_table.sv ====
// map table: architectural to physical mapping, source lookup and dest remap
module map_table (
  input  logic                 clock,
  input  logic                 reset,
  rename_if.map                alloc,
  input  rename_pkg::arch_reg_t dispatch_src1,
  input  rename_pkg::arch_reg_t dispatch_src2,
  output rename_pkg::phys_tag_t dispatch_src1_tag,
  output rename_pkg::phys_tag_t dispatch_src2_tag
);
  import rename_pkg::*;

  phys_tag_t map [num_arch];  // current speculative mapping

  // lookups see the map before this cycle's dispatch lands,
  // so a source equal to dest gets the old producer
  assign dispatch_src1_tag = map[dispatch_src1];  // operand 1 producer
  assign dispatch_src2_tag = map[dispatch_src2];  // operand 2 producer
  assign alloc.old_tag     = map[alloc.dest];     // freed when this inst retires

  // remap on accepted dispatch
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < num_arch; i++) begin
        map[i] <= phys_tag_t'(i);  // identity after reset
      end
    end else if (alloc.fire) begin
      map[alloc.dest] <= alloc.new_tag;  // dest now produced by the new tag
    end
  end

endmodule

// ==== source/reorder_buffer.sv ====
// reorder buffer: dispatch accept, completion marking, in-order retire of old tags
module reorder_buffer (
  input  logic                 clock,
  input  logic                 reset,
  rename_if.rob                alloc,
  // dispatch handshake
  input  logic                 dispatch_valid,
  input  rename_pkg::arch_reg_t dispatch_dest,
  output logic                 dispatch_ready,
  // completion snoop
  input  logic                 complete_valid,
  input  rename_pkg::phys_tag_t complete_tag,
  // retire handshake
  input  logic                 retire_ready,
  output logic                 retire_valid,
  output rename_pkg::arch_reg_t retire_dest,
  output rename_pkg::phys_tag_t retire_tag,
  output logic                 retire_fire,
  output rename_pkg::phys_tag_t retire_old_tag
);
  import rename_pkg::*;

  // entry payload
  arch_reg_t  dest_q    [rob_depth];  // architectural dest
  phys_tag_t  tag_q     [rob_depth];  // new tag
  phys_tag_t  old_tag_q [rob_depth];  // previous mapping
  // entry control
  rob_state_t state_q   [rob_depth];

  rob_index_t head;       // oldest entry
  rob_index_t tail;       // next free slot
  rob_count_t count;      // entries in flight
  logic       running;    // low through reset and one cycle after
  logic       full;
  logic [rob_depth-1:0] complete_hit;  // entry tag seen on the bus

  assign full = (count == rob_count_t'(rob_depth));

  // accept only with a tag and a slot
  assign dispatch_ready = running && alloc.tag_available && !full;
  assign alloc.fire     = dispatch_valid && dispatch_ready;
  assign alloc.dest     = dispatch_dest;  // map lookup of the old tag

  // head is offered once done, held until taken
  assign retire_valid   = (state_q[head] == done);
  assign retire_fire    = retire_valid && retire_ready;
  assign retire_dest    = dest_q[head];
  assign retire_tag     = tag_q[head];
  assign retire_old_tag = old_tag_q[head];  // back to the free list

  // tags of in-flight entries are unique, at most one hit
  always_comb begin
    for (int i = 0; i < rob_depth; i++) begin
      complete_hit[i] = complete_valid && (state_q[i] == issued) &&
                        (tag_q[i] == complete_tag);
    end
  end

  // entry states
  // fire and retire never hit the same slot since full blocks dispatch
  // and an empty rob has nothing to retire
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < rob_depth; i++) begin
        state_q[i] <= empty;
      end
    end else begin
      for (int i = 0; i < rob_depth; i++) begin
        if (alloc.fire && rob_index_t'(i) == tail) begin
          state_q[i] <= issued;  // new instruction
        end else if (retire_fire && rob_index_t'(i) == head) begin
          state_q[i] <= empty;  // popped
        end else if (complete_hit[i]) begin
          state_q[i] <= done;  // retire_valid rises next cycle at earliest
        end
      end
    end
  end

  // pointers and count
  always_ff @(posedge clock) begin
    if (reset) begin
      head    <= '0;
      tail    <= '0;
      count   <= '0;
      running <= 1'b0;
    end else begin
      running <= 1'b1;
      if (alloc.fire) begin
        tail <= tail + 1'b1;  // wraps at rob_depth
      end
      if (retire_fire) begin
        head <= head + 1'b1;
      end
      case ({alloc.fire, retire_fire})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // none or both
      endcase
    end
  end

  // payload written at the tail
  always_ff @(posedge clock) begin
    if (alloc.fire) begin
      dest_q[tail]    <= alloc.dest;
      tag_q[tail]     <= alloc.new_tag;
      old_tag_q[tail] <= alloc.old_tag;
    end
  end

endmodule

// ==== source/rename_core.sv ====
// rename core: register file, map table and reorder buffer joined by the rename bundle
module rename_core (
  input  logic                  clock,
  input  logic                  reset,
  // dispatch
  input  logic                  dispatch_valid,
  input  rename_pkg::arch_reg_t  dispatch_dest,
  input  rename_pkg::arch_reg_t  dispatch_src1,
  input  rename_pkg::arch_reg_t  dispatch_src2,
  output logic                  dispatch_ready,
  output rename_pkg::phys_tag_t  dispatch_tag,
  output rename_pkg::phys_tag_t  dispatch_src1_tag,
  output rename_pkg::phys_tag_t  dispatch_src2_tag,
  // operand reads
  input  rename_pkg::phys_tag_t  read_tag1   [rename_pkg::num_fu],
  input  rename_pkg::phys_tag_t  read_tag2   [rename_pkg::num_fu],
  output rename_pkg::reg_value_t read_value1 [rename_pkg::num_fu],
  output rename_pkg::reg_value_t read_value2 [rename_pkg::num_fu],
  // complete bus
  input  logic                  complete_valid,
  input  rename_pkg::phys_tag_t  complete_tag,
  input  rename_pkg::reg_value_t complete_result,
  // retire
  input  logic                  retire_ready,
  output logic                  retire_valid,
  output rename_pkg::arch_reg_t  retire_dest,
  output rename_pkg::phys_tag_t  retire_tag
);
  import rename_pkg::*;

  logic      retire_fire;     // head popped this cycle
  phys_tag_t retire_old_tag;  // tag going back to the free list

  rename_if alloc_bus ();  // dispatch allocation bundle

  assign dispatch_tag = alloc_bus.new_tag;  // lowest free tag, same cycle

  phys_reg_file phys_reg_file_inst (
    .clock           (clock),
    .reset           (reset),
    .alloc           (alloc_bus.prf),
    .complete_valid  (complete_valid),
    .complete_tag    (complete_tag),
    .complete_result (complete_result),
    .retire_fire     (retire_fire),
    .retire_old_tag  (retire_old_tag),
    .read_tag1       (read_tag1),
    .read_tag2       (read_tag2),
    .read_value1     (read_value1),
    .read_value2     (read_value2)
  );

  map_table map_table_inst (
    .clock             (clock),
    .reset             (reset),
    .alloc             (alloc_bus.map),
    .dispatch_src1     (dispatch_src1),
    .dispatch_src2     (dispatch_src2),
    .dispatch_src1_tag (dispatch_src1_tag),
    .dispatch_src2_tag (dispatch_src2_tag)
  );

  reorder_buffer reorder_buffer_inst (
    .clock          (clock),
    .reset          (reset),
    .alloc          (alloc_bus.rob),
    .dispatch_valid (dispatch_valid),
    .dispatch_dest  (dispatch_dest),
    .dispatch_ready (dispatch_ready),
    .complete_valid (complete_valid),
    .complete_tag   (complete_tag),
    .retire_ready   (retire_ready),
    .retire_valid   (retire_valid),
    .retire_dest    (retire_dest),
    .retire_tag     (retire_tag),
    .retire_fire    (retire_fire),
    .retire_old_tag (retire_old_tag)
  );

endmodule

// ==== sim/rename_checker.sv ====
// rename checker: reset, retire hold and dispatch tag properties of the rename core
module rename_checker (
  input logic                  clock,
  input logic                  reset,
  input logic                  dispatch_ready,
  input rename_pkg::phys_tag_t dispatch_tag,
  input logic                  retire_valid,
  input logic                  retire_ready,
  input rename_pkg::phys_tag_t retire_tag
);

  int unsigned failures = 0;  // assertion failures seen

  // nothing offered in the cycle after a reset edge
  quiet_after_reset: assert property (
    @(posedge clock) reset |=> !dispatch_ready && !retire_valid
  ) else begin
    failures++;
    $error("dispatch_ready or retire_valid high in the cycle after reset");
  end

  // head waits for retire_ready without changing
  head_held: assert property (
    @(posedge clock) disable iff (reset)
    retire_valid && !retire_ready |=> retire_valid && $stable(retire_tag)
  ) else begin
    failures++;
    $error("retire head dropped or changed while retire_ready was low");
  end

  // offered tag always defined
  tag_known: assert property (
    @(posedge clock) disable iff (reset) dispatch_ready |-> !$isunknown(dispatch_tag)
  ) else begin
    failures++;
    $error("dispatch_tag unknown while dispatch_ready is high");
  end

endmodule

bind rename_core rename_checker checker_inst (
  .clock          (clock),
  .reset          (reset),
  .dispatch_ready (dispatch_ready),
  .dispatch_tag   (dispatch_tag),
  .retire_valid   (retire_valid),
  .retire_ready   (retire_ready),
  .retire_tag     (retire_tag)
);

// ==== sim/rename_tb.sv ====
// rename testbench checking random dispatch, completion and retire against a reference model
module rename_tb;
  import rename_pkg::*;

  localparam int num_cycles = 800;  // checked cycles after reset
  localparam int period     = 100;

  logic       clock, reset, dispatch_valid, dispatch_ready;
  logic       complete_valid, retire_ready, retire_valid;
  arch_reg_t  dispatch_dest, dispatch_src1, dispatch_src2, retire_dest;
  phys_tag_t  dispatch_tag, dispatch_src1_tag, dispatch_src2_tag, complete_tag, retire_tag;
  phys_tag_t  read_tag1 [num_fu];
  phys_tag_t  read_tag2 [num_fu];
  reg_value_t read_value1 [num_fu];
  reg_value_t read_value2 [num_fu];
  reg_value_t complete_result;

  phys_tag_t   model_map [num_arch];     // arch to phys
  logic        model_free [num_phys];    // allocatable tags
  logic        model_done [num_phys];    // result seen on the bus
  reg_value_t  model_values [num_phys];
  phys_tag_t   rob_tag [$];              // in dispatch order
  arch_reg_t   rob_dest [$];
  phys_tag_t   rob_old [$];
  phys_tag_t   pending [$];              // dispatched and not completed yet
  logic        model_running;            // ready stays low one cycle after reset
  logic [31:0] lfsr_state = 32'd40;
  int          tag_errors, value_errors, arch_errors, bit_errors, other_errors;
  int          full_stalls, reused_tags, held_cycles, assert_errors;

  rename_core rename_core_inst (.*);

  // galois lfsr stepped once per bit
  function automatic logic [63:0] random_bits(input int n);
    logic [63:0] bits;
    bits = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = {1'b0, lfsr_state[31:1]} ^ (lfsr_state[0] ? 32'h80200003 : 32'h0);
      bits = {bits[62:0], lfsr_state[0]};
    end
    return bits;
  endfunction

  // first free tag counting up, -1 when none is left
  function automatic int lowest_free();
    for (int i = 0; i < num_phys; i++) begin
      if (model_free[i]) begin
        return i;
      end
    end
    return -1;
  endfunction

  // bus result overrides the stored value
  function automatic reg_value_t expected_read(input phys_tag_t tag);
    return (complete_valid && complete_tag == tag) ? complete_result : model_values[tag];
  endfunction

  task automatic check_tag(input string name, input phys_tag_t exp, input phys_tag_t act);
    if (act !== exp) begin
      tag_errors++;
      $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_value(input string name, input reg_value_t exp, input reg_value_t act);
    if (act !== exp) begin
      value_errors++;
      $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_arch(input string name, input arch_reg_t exp, input arch_reg_t act);
    if (act !== exp) begin
      arch_errors++;
      $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      bit_errors++;
      $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
    end
  endtask

  initial begin
    clock = 1'b0;
    forever #(period / 2) clock = ~clock;
  end

  // reset plus every test cycle plus slack
  initial begin
    #((8 + num_cycles + 50) * period);
    $display("timeout: the test loop did not finish in the expected time");
    $display("RESULT: FAIL");
    $finish;
  end

  initial begin
    int   lowest;
    int   pick;
    logic exp_ready, exp_retire, fire, retire;
    reset           = 1'b1;
    dispatch_valid  = 1'b0;
    dispatch_dest   = '0;
    dispatch_src1   = '0;
    dispatch_src2   = '0;
    complete_valid  = 1'b0;
    complete_tag    = '0;
    complete_result = '0;
    retire_ready    = 1'b0;
    model_running   = 1'b0;
    for (int f = 0; f < num_fu; f++) begin
      read_tag1[f] = '0;
      read_tag2[f] = '0;
    end
    for (int i = 0; i < num_phys; i++) begin
      if (i < num_arch) model_map[i] = phys_tag_t'(i);  // identity map
      model_free[i]   = (i >= num_arch);
      model_done[i]   = 1'b0;
      model_values[i] = '0;
    end
    repeat (8) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
    for (int cycle = 0; cycle < num_cycles; cycle++) begin
      dispatch_valid  = random_bits(2) != 0;
      dispatch_dest   = arch_reg_t'(random_bits(5));
      dispatch_src1   = random_bits(1) ? dispatch_dest : arch_reg_t'(random_bits(5));
      dispatch_src2   = arch_reg_t'(random_bits(5));
      complete_valid  = pending.size() > 0 && random_bits(2) != 0;
      pick            = complete_valid ? int'(random_bits(5)) % pending.size() : 0;
      complete_tag    = complete_valid ? pending[pick] : phys_tag_t'(random_bits(6));
      complete_result = random_bits(64);
      retire_ready    = (cycle % 200) >= 40 && random_bits(2) != 0;  // 40-cycle hold each 200
      for (int f = 0; f < num_fu; f++) begin
        read_tag1[f] = (complete_valid && random_bits(1)) ? complete_tag
                                                          : phys_tag_t'(random_bits(6));
        read_tag2[f] = (complete_valid && random_bits(1)) ? complete_tag
                                                          : phys_tag_t'(random_bits(6));
      end
      #(period / 4);  // settle before the rising edge
      lowest     = lowest_free();
      exp_ready  = model_running && lowest >= 0 && rob_tag.size() < rob_depth;
      exp_retire = rob_tag.size() > 0 && model_done[rob_tag[0]];
      check_bit("dispatch_ready", exp_ready, dispatch_ready);
      if (exp_ready) check_tag("dispatch_tag", phys_tag_t'(lowest), dispatch_tag);
      check_tag("dispatch_src1_tag", model_map[dispatch_src1], dispatch_src1_tag);
      check_tag("dispatch_src2_tag", model_map[dispatch_src2], dispatch_src2_tag);
      for (int f = 0; f < num_fu; f++) begin
        check_value($sformatf("read_value1[%0d]", f), expected_read(read_tag1[f]),
                    read_value1[f]);
        check_value($sformatf("read_value2[%0d]", f), expected_read(read_tag2[f]),
                    read_value2[f]);
      end
      check_bit("retire_valid", exp_retire, retire_valid);
      if (exp_retire) begin
        check_arch("retire_dest", rob_dest[0], retire_dest);
        check_tag("retire_tag", rob_tag[0], retire_tag);
      end
      fire   = exp_ready && dispatch_valid;
      retire = exp_retire && retire_ready;
      if (dispatch_valid && rob_tag.size() == rob_depth) full_stalls++;
      if (exp_retire && !retire_ready) held_cycles++;
      if (complete_valid) begin
        model_values[complete_tag] = complete_result;
        model_done[complete_tag]   = 1'b1;  // retire_valid next cycle
        pending.delete(pick);
      end
      if (retire) begin
        model_free[rob_old[0]] = 1'b1;  // allocatable after the edge
        void'(rob_tag.pop_front());
        void'(rob_dest.pop_front());
        void'(rob_old.pop_front());
      end
      if (fire) begin
        if (lowest < num_arch) reused_tags++;  // only reachable through retire
        rob_tag.push_back(phys_tag_t'(lowest));
        rob_dest.push_back(dispatch_dest);
        rob_old.push_back(model_map[dispatch_dest]);
        pending.push_back(phys_tag_t'(lowest));
        model_map[dispatch_dest] = phys_tag_t'(lowest);
        model_free[lowest]       = 1'b0;
        model_done[lowest]       = 1'b0;
      end
      model_running = 1'b1;
      @(negedge clock);
    end
    if (full_stalls == 0 || reused_tags == 0 || held_cycles == 0) begin
      other_errors++;
      $display("test gap: full rob stalls %0d, reused tags %0d, held heads %0d",
               full_stalls, reused_tags, held_cycles);
    end
    assert_errors = rename_core_inst.checker_inst.failures;
    $display("errors: tag %0d value %0d arch %0d bit %0d other %0d assertion %0d",
             tag_errors, value_errors, arch_errors, bit_errors, other_errors, assert_errors);
    if (tag_errors + value_errors + arch_errors + bit_errors + other_errors
        + assert_errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== verilog.f ====
source/rename_pkg.sv
source/rename_if.sv
source/phys_reg_file.sv
source/map_table.sv
source/reorder_buffer.sv
source/rename_core.sv
sim/rename_checker.sv
sim/rename_tb.sv
